// File: Makefile
# Verilator build for the ALU instruction core.
# make lint | make sim | make clean

VERILATOR ?= verilator
TOP ?= cpuAluCore_tb
RTL_TOP ?= cpuAluCore
FILELIST ?= cpuAluCore.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_MSG ?= Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

# Passes only when the pass line shows up in the simulation output.
sim: $(OBJDIR)/V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// File: cpuAluCore.f
+incdir+rtl
rtl/cpuAluPkg.sv
rtl/phaseSequencer.sv
rtl/aluGroupDecoder.sv
rtl/registerFile.sv
rtl/aluExecute.sv
rtl/resultStage.sv
rtl/cpuAluCore.sv
sim/cpuAluCore_tb.sv

// File: rtl/aluExecute.sv
// ALU execute stage.
// Picks the operands, computes one of sixteen operations with Z/N/C/V
// and registers result and flags at the end of the execute phase.
`include "cpuAlu_cfg.svh"

module aluExecute import cpuAluPkg::*; (
	input  logic CLK,
	input  logic reset,
	input  logic execute,
	input  aluOpT aluOp,
	input  srcAT srcA,
	input  srcBT srcB,
	input  logic [`DATA_WIDTH-1:0] rdA,
	input  logic [`DATA_WIDTH-1:0] rdB,
	input  logic [3:0] argA,
	input  logic [3:0] argB,
	input  logic carryIn,
	output logic [`DATA_WIDTH-1:0] result,
	output flagsT newFlags
);

	localparam int msb = `DATA_WIDTH - 1;
	localparam logic [`DATA_WIDTH:0] oneExt = {{`DATA_WIDTH{1'b0}}, 1'b1};

	logic [`DATA_WIDTH-1:0] opA;
	logic [`DATA_WIDTH-1:0] opB;
	logic [`DATA_WIDTH-1:0] res;
	logic [`DATA_WIDTH:0] sum; // Extra bit is carry or borrow.
	logic [`DATA_WIDTH:0] cinExt;
	logic cOut;
	logic vOut;

	assign opA = (srcA == SRCA_REG_A) ? rdA : '0;
	assign cinExt = {{`DATA_WIDTH{1'b0}}, (aluOp == ALU_ADC || aluOp == ALU_SBC) && carryIn};

	always_comb begin
		case (srcB)
			SRCB_U4: opB = {{(`DATA_WIDTH-4){1'b0}}, argB};
			SRCB_U8: opB = {{(`DATA_WIDTH-8){1'b0}}, argA, argB};
			SRCB_U8H: opB = {argA, argB, rdB[`DATA_WIDTH-9:0]}; // Byte above RB low.
			default: opB = rdB;
		endcase
	end

	always_comb begin
		sum = '0;
		res = '0;
		cOut = 1'b0;
		vOut = 1'b0;
		unique case (aluOp)
			ALU_MOV: res = opB;
			ALU_ADD, ALU_ADC: begin
				sum = {1'b0, opA} + {1'b0, opB} + cinExt;
				res = sum[msb:0];
				cOut = sum[`DATA_WIDTH];
				vOut = (opA[msb] == opB[msb]) && (res[msb] != opA[msb]);
			end
			ALU_SUB, ALU_SBC: begin
				sum = {1'b0, opA} - {1'b0, opB} - cinExt;
				res = sum[msb:0];
				cOut = sum[`DATA_WIDTH]; // Borrow.
				vOut = (opA[msb] != opB[msb]) && (res[msb] != opA[msb]);
			end
			ALU_AND: res = opA & opB;
			ALU_OR: res = opA | opB;
			ALU_XOR: res = opA ^ opB;
			ALU_NOT: res = ~opA;
			ALU_SHL: begin
				res = {opA[msb-1:0], 1'b0};
				cOut = opA[msb]; // Bit shifted out.
			end
			ALU_SHR: begin
				res = {1'b0, opA[msb:1]};
				cOut = opA[0];
			end
			ALU_ROL: begin
				res = {opA[msb-1:0], opA[msb]};
				cOut = opA[msb];
			end
			ALU_ROR: begin
				res = {opA[0], opA[msb:1]};
				cOut = opA[0];
			end
			ALU_INC: begin
				sum = {1'b0, opA} + oneExt;
				res = sum[msb:0];
				cOut = sum[`DATA_WIDTH];
				vOut = ~opA[msb] & res[msb]; // 0x7fff wraps.
			end
			ALU_DEC: begin
				sum = {1'b0, opA} - oneExt;
				res = sum[msb:0];
				cOut = sum[`DATA_WIDTH];
				vOut = opA[msb] & ~res[msb]; // 0x8000 wraps.
			end
			ALU_SWAP: res = {opA[7:0], opA[msb:8]}; // Byte swap.
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			result <= '0;
			newFlags <= '0;
		end else if (execute) begin
			result <= res;
			newFlags <= '{z: (res == '0), n: res[msb], c: cOut, v: vOut};
		end
	end

endmodule

// File: rtl/aluGroupDecoder.sv
// ALU group decoder.
// Turns group 3 fields into register-file enables, address selects,
// operand sources and the condition-code load, stepped by phase.
`include "cpuAlu_cfg.svh"

module aluGroupDecoder import cpuAluPkg::*; (
	input  logic CLK,
	input  logic reset,
	input  logic [`INSTR_WIDTH-1:0] instr,
	input  logic fetch,
	input  logic decode,
	input  logic execute,
	input  logic commit,
	output logic regAEn,
	output logic regBEn,
	output logic regAWen,
	output addrASelT regAAddrSel,
	output addrBSelT regBAddrSel,
	output aluOpT aluOp,
	output logic ccLoad,
	output srcAT srcA,
	output srcBT srcB,
	output logic [3:0] argA,
	output logic [3:0] argB
);

	groupT group;
	argModeT argMode;
	logic isAlu;
	logic rdNeedA; // Port A read needed.
	logic rdNeedB; // Port B read needed.
	logic wrNeedA; // Result goes back through port A.

	assign group = groupT'(instr[15:14]);
	assign aluOp = aluOpT'(instr[13:10]);
	assign argMode = argModeT'(instr[9:8]);
	assign argA = instr[7:4];
	assign argB = instr[3:0];
	assign isAlu = (group == GROUP_ARITHLOGIC);

	always_comb begin
		srcA = SRCA_REG_A; // Only source for operand A.
		srcB = SRCB_REG_B;
		regAAddrSel = ADDRA_ARGA;
		regBAddrSel = ADDRB_ARGB;
		rdNeedA = 1'b0;
		rdNeedB = 1'b0;
		wrNeedA = 1'b0;
		if (isAlu) begin
			case (argMode)
				ARG_REG_REG: begin // Ra op Rb.
					rdNeedA = 1'b1;
					rdNeedB = 1'b1;
					wrNeedA = 1'b1;
				end
				ARG_REG_U4: begin // Ra op u4.
					srcB = SRCB_U4;
					rdNeedA = 1'b1;
					wrNeedA = 1'b1;
				end
				ARG_REGB_U8: begin // RB op u8.
					regAAddrSel = ADDRA_RB;
					srcB = SRCB_U8;
					rdNeedA = 1'b1;
					rdNeedB = 1'b1;
					wrNeedA = 1'b1;
				end
				default: begin // RA op u8.RB.
					regAAddrSel = ADDRA_RA;
					regBAddrSel = ADDRB_RB;
					srcB = SRCB_U8H;
					rdNeedA = 1'b1;
					rdNeedB = 1'b1;
					wrNeedA = 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			regAEn <= 1'b0;
			regBEn <= 1'b0;
			regAWen <= 1'b0;
			ccLoad <= 1'b0;
		end else if (fetch) begin
			regAEn <= rdNeedA; // Reads armed for the decode cycle.
			regBEn <= rdNeedB;
			regAWen <= 1'b0; // Drop last instruction's write.
			ccLoad <= 1'b0;
		end else if (decode) begin
			regAEn <= rdNeedA;
			regBEn <= rdNeedB;
		end else if (execute) begin
			regAEn <= rdNeedA;
			regBEn <= rdNeedB;
			ccLoad <= isAlu && (aluOp != ALU_MOV); // MOV keeps the flags.
		end else if (commit) begin
			regAEn <= wrNeedA; // Port A now owned by the write.
			regBEn <= 1'b0;
			regAWen <= wrNeedA;
		end
	end

endmodule

// File: rtl/cpuAluCore.sv
// ALU instruction core.
// Sequencer, group 3 decoder, register file, ALU and result stage.
`include "cpuAlu_cfg.svh"

module cpuAluCore import cpuAluPkg::*; (
	input  logic CLK,
	input  logic reset,
	input  logic start,
	input  logic [`INSTR_WIDTH-1:0] instruction,
	output logic busy,
	output logic wbValid,
	output logic [`REG_ADDR_WIDTH-1:0] wbAddr,
	output logic [`DATA_WIDTH-1:0] wbData,
	output flagsT flags
);

	logic [`INSTR_WIDTH-1:0] instr;
	logic fetch;
	logic decode;
	logic execute;
	logic commit;
	logic regAEn;
	logic regBEn;
	logic regAWen;
	logic ccLoad;
	addrASelT regAAddrSel;
	addrBSelT regBAddrSel;
	aluOpT aluOp;
	srcAT srcA;
	srcBT srcB;
	logic [3:0] argA;
	logic [3:0] argB;
	logic [`DATA_WIDTH-1:0] rdA;
	logic [`DATA_WIDTH-1:0] rdB;
	logic [`DATA_WIDTH-1:0] result;
	logic [`REG_ADDR_WIDTH-1:0] writeAddr;
	flagsT newFlags;
	logic carryOut;

	phaseSequencer sequencer (.CLK, .reset, .start, .instruction, .fetch, .decode, .execute,
		.commit, .busy, .instr);

	aluGroupDecoder decoder (.CLK, .reset, .instr, .fetch, .decode, .execute, .commit,
		.regAEn, .regBEn, .regAWen, .regAAddrSel, .regBAddrSel, .aluOp, .ccLoad,
		.srcA, .srcB, .argA, .argB);

	registerFile regFile (.CLK, .reset, .regAEn, .regBEn, .regAAddrSel, .regBAddrSel,
		.argA, .argB, .wbValid, .wbAddr, .wbData, .rdA, .rdB, .writeAddr);

	aluExecute alu (.CLK, .reset, .execute, .aluOp, .srcA, .srcB, .rdA, .rdB, .argA, .argB,
		.carryIn(carryOut), .result, .newFlags);

	resultStage resStage (.CLK, .reset, .commit, .regAWen, .ccLoad, .result, .newFlags,
		.writeAddr, .wbValid, .wbAddr, .wbData, .flags, .carryOut);

endmodule

// File: rtl/cpuAluPkg.sv
// ALU core types.
// Field enumerations and the condition-code flag struct.
`include "cpuAlu_cfg.svh"

package cpuAluPkg;

	typedef enum logic [1:0] {
		GROUP_SYSTEM = `GRP_SYS,
		GROUP_LOADSTORE = `GRP_LDST,
		GROUP_JUMP = `GRP_JUMP,
		GROUP_ARITHLOGIC = `GRP_ALU
	} groupT;

	typedef enum logic [3:0] {
		ALU_MOV, ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_AND, ALU_OR, ALU_XOR,
		ALU_NOT, ALU_SHL, ALU_SHR, ALU_ROL, ALU_ROR, ALU_INC, ALU_DEC, ALU_SWAP
	} aluOpT; // Encoded 0 to 15 in this order.

	typedef enum logic [1:0] {
		ARG_REG_REG = `MODE_REG_REG,
		ARG_REG_U4 = `MODE_REG_U4,
		ARG_REGB_U8 = `MODE_REGB_U8,
		ARG_REGA_U8RB = `MODE_REGA_U8RB
	} argModeT;

	typedef enum logic {SRCA_REG_A = `SRCA_SEL_REG_A} srcAT;

	typedef enum logic [1:0] {
		SRCB_REG_B = `SRCB_SEL_REG_B,
		SRCB_U4 = `SRCB_SEL_U4,
		SRCB_U8 = `SRCB_SEL_U8,
		SRCB_U8H = `SRCB_SEL_U8H
	} srcBT;

	typedef enum logic [1:0] {
		ADDRA_ARGA = `ADDRA_SEL_ARGA,
		ADDRA_RA = `ADDRA_SEL_RA,
		ADDRA_RB = `ADDRA_SEL_RB
	} addrASelT;

	typedef enum logic {ADDRB_ARGB = `ADDRB_SEL_ARGB, ADDRB_RB = `ADDRB_SEL_RB} addrBSelT;

	typedef struct packed {
		logic z; // Zero.
		logic n; // Negative.
		logic c; // Carry, or borrow on subtract.
		logic v; // Signed overflow.
	} flagsT;

endpackage

// File: rtl/cpuAlu_cfg.svh
// ALU core configuration.
// Data path sizes, fixed register indices and selector encodings.
`ifndef CPU_ALU_CFG_SVH
`define CPU_ALU_CFG_SVH

`define DATA_WIDTH      16 // Data path width.
`define INSTR_WIDTH     16 // Instruction word width.
`define REG_COUNT       16 // Register file depth.
`define REG_ADDR_WIDTH  4  // Register index width.
`define REG_RA          4'd14 // Fixed register RA.
`define REG_RB          4'd15 // Fixed register RB.

// Instruction group field, bits 15:14.
`define GRP_SYS         2'd0
`define GRP_LDST        2'd1
`define GRP_JUMP        2'd2
`define GRP_ALU         2'd3

// ALU argument mode field, bits 9:8.
`define MODE_REG_REG    2'd0 // Ra, Rb.
`define MODE_REG_U4     2'd1 // Ra, u4.
`define MODE_REGB_U8    2'd2 // RB, u8.
`define MODE_REGA_U8RB  2'd3 // RA, u8.RB.

`define SRCA_SEL_REG_A  1'b0 // Port A read data.

`define SRCB_SEL_REG_B  2'd0 // Port B read data.
`define SRCB_SEL_U4     2'd1 // Zero-extended nibble.
`define SRCB_SEL_U8     2'd2 // Zero-extended byte.
`define SRCB_SEL_U8H    2'd3 // Byte above RB low byte.

`define ADDRA_SEL_ARGA  2'd0
`define ADDRA_SEL_RA    2'd1
`define ADDRA_SEL_RB    2'd2

`define ADDRB_SEL_ARGB  1'b0
`define ADDRB_SEL_RB    1'b1

`endif

// File: rtl/phaseSequencer.sv
// Instruction phase sequencer.
// Steps one instruction through FETCH, DECODE, EXECUTE, COMMIT and write-back.
`include "cpuAlu_cfg.svh"

module phaseSequencer (
	input  logic CLK,
	input  logic reset,
	input  logic start,
	input  logic [`INSTR_WIDTH-1:0] instruction,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit,
	output logic busy,
	output logic [`INSTR_WIDTH-1:0] instr
);

	// One bit per phase, all clear when idle.
	// Bit 4 is the write-back cycle.
	logic [4:0] phase;
	logic accept;

	assign accept = start & ~busy; // Starts during an instruction are dropped.

	always_ff @(posedge CLK) begin
		if (reset) begin
			phase <= '0;
		end else begin
			phase <= {phase[3:0], accept}; // Advance one phase per cycle.
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) begin
			instr <= instruction; // Held until the next accepted start.
		end
	end

	assign fetch = phase[0];
	assign decode = phase[1];
	assign execute = phase[2];
	assign commit = phase[3];
	assign busy = |phase; // Covers write-back as well.

endmodule

// File: rtl/registerFile.sv
// Register file.
// Sixteen registers, two registered read ports and one write port.
`include "cpuAlu_cfg.svh"

module registerFile import cpuAluPkg::*; (
	input  logic CLK,
	input  logic reset,
	input  logic regAEn,
	input  logic regBEn,
	input  addrASelT regAAddrSel,
	input  addrBSelT regBAddrSel,
	input  logic [3:0] argA,
	input  logic [3:0] argB,
	input  logic wbValid,
	input  logic [`REG_ADDR_WIDTH-1:0] wbAddr,
	input  logic [`DATA_WIDTH-1:0] wbData,
	output logic [`DATA_WIDTH-1:0] rdA,
	output logic [`DATA_WIDTH-1:0] rdB,
	output logic [`REG_ADDR_WIDTH-1:0] writeAddr
);

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
	logic [`REG_ADDR_WIDTH-1:0] addrA;
	logic [`REG_ADDR_WIDTH-1:0] addrB;

	always_comb begin
		case (regAAddrSel)
			ADDRA_RA: addrA = `REG_RA;
			ADDRA_RB: addrA = `REG_RB;
			default: addrA = argA;
		endcase
		addrB = (regBAddrSel == ADDRB_RB) ? `REG_RB : argB;
	end

	assign writeAddr = addrA; // Port A is also the write-back target.

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wbValid) begin
			regs[wbAddr] <= wbData;
		end
	end

	always_ff @(posedge CLK) begin
		if (regAEn) rdA <= regs[addrA]; // Old value on a same-cycle write.
		if (regBEn) rdB <= regs[addrB];
	end

endmodule

// File: rtl/resultStage.sv
// Result stage.
// Register write-back pulse, address and data, plus the flag register.
`include "cpuAlu_cfg.svh"

module resultStage import cpuAluPkg::*; (
	input  logic CLK,
	input  logic reset,
	input  logic commit,
	input  logic regAWen,
	input  logic ccLoad,
	input  logic [`DATA_WIDTH-1:0] result,
	input  flagsT newFlags,
	input  logic [`REG_ADDR_WIDTH-1:0] writeAddr,
	output logic wbValid,
	output logic [`REG_ADDR_WIDTH-1:0] wbAddr,
	output logic [`DATA_WIDTH-1:0] wbData,
	output flagsT flags,
	output logic carryOut
);

	logic commitSeen; // High only in the cycle after commit.

	always_ff @(posedge CLK) begin
		if (reset) begin
			commitSeen <= 1'b0;
			flags <= '0;
		end else begin
			commitSeen <= commit;
			if (commit && ccLoad) flags <= newFlags; // Visible with wbValid.
		end
	end

	always_ff @(posedge CLK) begin
		if (commit) begin
			wbAddr <= writeAddr;
			wbData <= result;
		end
	end

	assign wbValid = regAWen & commitSeen; // Write enable lingers, pulse does not.
	assign carryOut = flags.c; // For ADC and SBC.

endmodule

// File: sim/cpuAluCore_tb.sv
// Testbench for the ALU instruction core.
// Runs ALU and non-ALU instructions against a register and flag model.
// Concurrent assertions check write-back timing, address, data and flags.
`include "cpuAlu_cfg.svh"

module cpuAluCore_tb import cpuAluPkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int clkPeriod = 4;
	localparam int maxInstrs = 160; // Upper bound on instructions issued.
	localparam int doneLimit = 12; // Cycles allowed for busy to fall.

	logic CLK;
	logic reset;
	logic start;
	logic [`INSTR_WIDTH-1:0] instruction;
	logic busy;
	logic wbValid;
	logic [`REG_ADDR_WIDTH-1:0] wbAddr;
	logic [`DATA_WIDTH-1:0] wbData;
	flagsT flags;

	logic [`DATA_WIDTH-1:0] regModel [`REG_COUNT]; // Expected register contents.
	flagsT flagModel; // Expected flags before the current instruction.
	flagsT expFlags; // Expected flags after it.
	logic [`REG_ADDR_WIDTH-1:0] expAddr;
	logic [`DATA_WIDTH-1:0] expData;
	logic expWrite; // Current instruction writes back.
	logic expAccept; // Start now driven should be taken and write back.
	logic [4:0] acceptHist; // Expected ALU starts, one bit per cycle.
	int wbCount;
	int checkErrors;
	int assertErrors;
	int testNum;
	int errBase;
	int instrCount;

	cpuAluCore uut (.CLK, .reset, .start, .instruction, .busy, .wbValid, .wbAddr, .wbData,
		.flags);

	initial begin
		CLK = 1'b0;
		forever #(clkPeriod / 2) CLK = ~CLK;
	end

	always @(posedge CLK) begin
		if (reset) begin
			acceptHist <= '0;
			wbCount <= 0;
		end else begin
			acceptHist <= {acceptHist[3:0], start && expAccept};
			if (wbValid) wbCount <= wbCount + 1;
		end
	end

	wbTiming: assert property (@(posedge CLK) disable iff (reset) wbValid == acceptHist[4])
		else begin
			assertErrors++;
			$display("Mismatch wbValid: got %h, expected %h", $sampled(wbValid),
				$sampled(acceptHist[4]));
		end

	wbAddrCheck: assert property (@(posedge CLK) disable iff (reset)
		wbValid |-> wbAddr == expAddr)
		else begin
			assertErrors++;
			$display("Mismatch wbAddr: got %h, expected %h", $sampled(wbAddr), $sampled(expAddr));
		end

	wbDataCheck: assert property (@(posedge CLK) disable iff (reset)
		wbValid |-> wbData == expData)
		else begin
			assertErrors++;
			$display("Mismatch wbData: got %h, expected %h", $sampled(wbData), $sampled(expData));
		end

	flagsCheck: assert property (@(posedge CLK) disable iff (reset)
		wbValid |-> flags == expFlags)
		else begin
			assertErrors++;
			$display("Mismatch flags: got %h, expected %h", $sampled(flags), $sampled(expFlags));
		end

	// Group, op, mode, argA, argB from high to low.
	function automatic logic [15:0] encode(input logic [1:0] grp, input logic [3:0] op,
		input logic [1:0] mode, input logic [3:0] aSel, input logic [3:0] bSel);
		return {grp, op, mode, aSel, bSel};
	endfunction

	// Expected write-back and flags for one instruction.
	task automatic predict(input logic [15:0] ins);
		logic [3:0] op;
		logic [3:0] aSel;
		logic [3:0] bSel;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		logic cf;
		logic vf;
		int ua;
		int ub;
		int sa;
		int sb;
		int ci;
		int full;
		int sfull;
		op = ins[13:10];
		aSel = ins[7:4];
		bSel = ins[3:0];
		expWrite = (ins[15:14] == GROUP_ARITHLOGIC);
		case (ins[9:8])
			ARG_REG_REG: begin
				expAddr = aSel;
				a = regModel[aSel];
				b = regModel[bSel];
			end
			ARG_REG_U4: begin
				expAddr = aSel;
				a = regModel[aSel];
				b = {12'd0, bSel}; // Zero-extended nibble.
			end
			ARG_REGB_U8: begin
				expAddr = `REG_RB;
				a = regModel[`REG_RB];
				b = {8'd0, aSel, bSel};
			end
			default: begin
				expAddr = `REG_RA;
				a = regModel[`REG_RA];
				b = {aSel, bSel, regModel[`REG_RB][7:0]}; // Immediate over RB low byte.
			end
		endcase
		ua = int'(a);
		ub = int'(b);
		sa = int'($signed(a));
		sb = int'($signed(b));
		ci = (op == ALU_ADC || op == ALU_SBC) ? int'(flagModel.c) : 0; // Previous carry.
		cf = 1'b0;
		vf = 1'b0;
		full = 0;
		sfull = 0;
		case (op)
			ALU_MOV: res = b;
			ALU_ADD, ALU_ADC, ALU_INC: begin
				full = (op == ALU_INC) ? ua + 1 : ua + ub + ci;
				sfull = (op == ALU_INC) ? sa + 1 : sa + sb + ci;
				res = full[15:0];
				cf = full > 65535; // Unsigned carry out.
				vf = sfull > 32767 || sfull < -32768;
			end
			ALU_SUB, ALU_SBC, ALU_DEC: begin
				full = (op == ALU_DEC) ? ua - 1 : ua - ub - ci;
				sfull = (op == ALU_DEC) ? sa - 1 : sa - sb - ci;
				res = full[15:0];
				cf = full < 0; // Borrow.
				vf = sfull > 32767 || sfull < -32768;
			end
			ALU_AND: res = a & b;
			ALU_OR: res = a | b;
			ALU_XOR: res = a ^ b;
			ALU_NOT: res = ~a;
			ALU_SHL: begin
				res = a << 1;
				cf = a[15];
			end
			ALU_SHR: begin
				res = a >> 1;
				cf = a[0];
			end
			ALU_ROL: begin
				res = (a << 1) | (a >> 15);
				cf = a[15];
			end
			ALU_ROR: begin
				res = (a >> 1) | (a << 15);
				cf = a[0];
			end
			default: res = {a[7:0], a[15:8]}; // SWAP.
		endcase
		expData = res;
		if (expWrite && op != ALU_MOV) expFlags = {res == 16'd0, res[15], cf, vf};
		else expFlags = flagModel;
	endtask

	// Called at a falling edge with the core idle; returns once busy falls.
	task automatic issue(input logic [15:0] ins, input logic poke);
		int startCount;
		int waited;
		predict(ins);
		startCount = wbCount;
		start = 1'b1;
		expAccept = expWrite;
		instruction = ins;
		@(negedge CLK);
		start = 1'b0;
		expAccept = 1'b0;
		assert (busy == 1'b1) else begin
			checkErrors++;
			$display("Start was not accepted while the core was idle");
		end
		if (poke) begin
			start = 1'b1; // Should be dropped while busy.
			instruction = encode(GROUP_ARITHLOGIC, 4'($urandom), ARG_REG_REG, 4'($urandom),
				4'($urandom));
			repeat (5) @(negedge CLK); // Held through the write-back cycle.
			start = 1'b0;
		end
		waited = 0;
		while (busy && waited < doneLimit) begin
			@(negedge CLK);
			waited++;
		end
		if (busy) begin
			checkErrors++;
			$display("Timeout waiting for busy to fall");
		end
		assert (wbCount - startCount == (expWrite ? 1 : 0)) else begin
			checkErrors++;
			$display("Mismatch wbValid count: got %h, expected %h", wbCount - startCount,
				expWrite ? 1 : 0);
		end
		assert (flags == expFlags) else begin
			checkErrors++;
			$display("Mismatch flags: got %h, expected %h", flags, expFlags);
		end
		if (expWrite) regModel[expAddr] = expData;
		flagModel = expFlags;
		instrCount++;
	endtask

	// Low byte into RB, full word into RA, then copied to the target.
	task automatic loadReg(input int k, input logic [15:0] value);
		issue(encode(GROUP_ARITHLOGIC, ALU_MOV, ARG_REGB_U8, value[7:4], value[3:0]), 1'b0);
		issue(encode(GROUP_ARITHLOGIC, ALU_MOV, ARG_REGA_U8RB, value[15:12], value[11:8]), 1'b0);
		if (k < 14) issue(encode(GROUP_ARITHLOGIC, ALU_MOV, ARG_REG_REG, 4'(k), `REG_RA), 1'b0);
	endtask

	task automatic endTest(input string name);
		testNum++;
		$display("Test %0d %s finished, %0d errors", testNum, name,
			checkErrors + assertErrors - errBase);
		errBase = checkErrors + assertErrors;
	endtask

	initial begin
		#(maxInstrs * 8 * clkPeriod + 50 * clkPeriod);
		$display("Watchdog expired before the tests finished");
		$display("Regression failed");
		$finish;
	end

	initial begin
		void'($urandom(74045));
		reset = 1'b1;
		start = 1'b0;
		instruction = '0;
		flagModel = '0;
		expFlags = '0;
		expAddr = '0;
		expData = '0;
		expWrite = 1'b0;
		expAccept = 1'b0;
		checkErrors = 0;
		assertErrors = 0;
		testNum = 0;
		errBase = 0;
		instrCount = 0;
		for (int i = 0; i < `REG_COUNT; i++) regModel[i] = '0; // Cleared by reset.
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		reset = 1'b0;

		assert (busy == 1'b0) else begin
			checkErrors++;
			$display("Mismatch busy: got %h, expected %h", busy, 1'b0);
		end
		assert (wbValid == 1'b0) else begin
			checkErrors++;
			$display("Mismatch wbValid: got %h, expected %h", wbValid, 1'b0);
		end
		assert (flags == 4'h0) else begin
			checkErrors++;
			$display("Mismatch flags: got %h, expected %h", flags, 4'h0);
		end
		issue(encode(GROUP_ARITHLOGIC, ALU_MOV, ARG_REGB_U8, 4'ha, 4'h5), 1'b0);
		endTest("reset and MOV u8");

		for (int k = 0; k < 14; k++) loadReg(k, 16'($urandom));
		for (int rep = 0; rep < 3; rep++) begin
			for (int op = 0; op < 16; op++) begin
				issue(encode(GROUP_ARITHLOGIC, 4'(op), ARG_REG_REG, 4'($urandom), 4'($urandom)),
					1'b0);
			end
		end
		endTest("register-register ops");

		for (int i = 0; i < 16; i++) begin
			issue(encode(GROUP_ARITHLOGIC, 4'($urandom), ARG_REG_U4, 4'($urandom), 4'($urandom)),
				1'b0);
		end
		for (int i = 0; i < 8; i++) begin
			issue(encode(GROUP_ARITHLOGIC, (i % 2 == 1) ? ALU_ADD : ALU_MOV, ARG_REGA_U8RB,
				4'($urandom), 4'($urandom)), 1'b0);
		end
		endTest("immediate modes");

		for (int i = 0; i < 4; i++) begin
			issue(encode(GROUP_ARITHLOGIC, 4'($urandom), ARG_REG_REG, 4'($urandom), 4'($urandom)),
				1'b1);
		end
		endTest("start while busy");

		for (int g = 0; g < 6; g++) begin
			issue(encode(2'(g % 3), 4'($urandom), 2'($urandom), 4'($urandom), 4'($urandom)), 1'b0);
		end
		for (int k = 0; k < 4; k++) begin
			issue(encode(GROUP_ARITHLOGIC, ALU_OR, ARG_REG_REG, 4'(k), 4'(k)), 1'b0); // Read back.
		end
		endTest("other groups");

		repeat (2) @(negedge CLK);
		$display("Tests: %0d, instructions: %0d, errors: %0d", testNum, instrCount,
			checkErrors + assertErrors);
		if (checkErrors + assertErrors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule
